// File: all.f
src/ks10BusPkg.sv
src/cslPkg.sv
src/phaseGen.sv
src/cslRegs.sv
src/busArb.sv
src/ks10Core.sv
verif/ks10Check.sv
verif/ks10Tb.sv

// File: Bender.yml
package:
  name: ks10_glue

sources:
  # Packages first, then the RTL in dependency order
  - src/ks10BusPkg.sv
  - src/cslPkg.sv
  - src/phaseGen.sv
  - src/cslRegs.sv
  - src/busArb.sv
  - src/ks10Core.sv

  # Testbench, top module ks10Tb
  - target: test
    files:
      - verif/ks10Check.sv
      - verif/ks10Tb.sv

// File: verif/ks10Tb.sv
// Testbench top for the KS10 glue logic that applies a stimulus table, run with ks10Tb as top
`timescale 1ns/1ps

module ks10Tb
   import ks10BusPkg::*;
   import cslPkg::*;
();

   localparam int cyclesPerStep = 8;
   localparam int tmoMargin     = 20;

   typedef enum logic [3:0] {
      opWrLock, opWr, opWrFix, opRd, opSts,
      opMdm, opReq, opGnt, opSrv, opIdle
   } op_e;

   typedef struct packed {
      op_e         op;
      cslAddr_e    addr;
      logic [31:0] data;
      logic [5:0]  reqPat;   // Bit 0 cpu, bit 1 csl, bits 2 to 5 uba1 to uba4
      logic [31:0] expv;
   } step_t;

   logic              clkT = 1'b0;
   logic              memRST, cpuClk, cslRst, cslWr, cslRd, cpuHalt, cpuRun, memAck;
   clkPhase_e         phase;
   cslAddr_e          cslAddr;
   logic [31:0]       cslWrData, cslRdData;
   logic [3:0]        ctrl;
   modemOut_t         modemOut;
   modemIn_t          modemIn;
   busReq_t           cpuReq, cslReq, memReq;
   busReq_t           ubaReq [numBridge];
   busSrc_e           grant;
   logic [numReq-1:0] ackOut;
   logic [5:0]        activeReq;
   logic [31:0]       shadow [4];   // Expected register contents
   step_t             steps [$];
   string             names [$];
   integer            seed;
   int                errCount;
   int                cycleCount = 0;
   int                tmoLimit = 1000;

   ks10Core dut (.*);
   ks10Check chk (.*);

   always #5 clkT = ~clkT;

   always @(posedge clkT)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= tmoLimit)
      begin
         $display("Run timed out after %0d cycles with the table unfinished", cycleCount);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic nextCycle();
      @(posedge clkT);
      #1;
   endtask

   function automatic busReq_t reqDrive(input int idx);
      busReq_t r;
      r.req   = 1'b1;
      r.write = idx[0];
      r.addr  = 18'h2000 + 18'(idx);
      r.data  = 36'hA_5000_0000 + 36'(idx);   // Distinct word per requester
      return r;
   endfunction

   task automatic driveReqs();
      cpuReq = activeReq[0] ? reqDrive(0) : busReq_t'(0);
      cslReq = activeReq[1] ? reqDrive(1) : busReq_t'(0);
      for (int i = 0; i < numBridge; i++)
         ubaReq[i] = activeReq[i + 2] ? reqDrive(i + 2) : busReq_t'(0);
   endtask

   task automatic writeReg(input cslAddr_e a, input logic [31:0] d, input bit keep);
      cslWr     = 1'b1;
      cslAddr   = a;
      cslWrData = d;
      nextCycle();
      cslWr = 1'b0;
      if (keep)
         shadow[int'(a)] = d & ((a == regModem) ? 32'h1F : 32'hF);
   endtask

   task automatic readReg(input string name, input cslAddr_e a, input logic [31:0] expv);
      cslRd   = 1'b1;
      cslAddr = a;
      nextCycle();
      cslRd = 1'b0;
      @(negedge clkT);
      chk.checkSig(name, "rdData", expv);
      nextCycle();
   endtask

   task automatic applyStep(input step_t s, input string name);
      int idx;
      idx = s.expv - 1;   // Requester index of the expected winner
      case (s.op)
         opWrLock:
         begin
            repeat (3) nextCycle();   // Last cycle with the console still in reset
            writeReg(s.addr, s.data, 1'b0);
            while (cslRst)
               nextCycle();
         end
         opWr:    writeReg(s.addr, $random(seed), 1'b1);
         opWrFix: writeReg(s.addr, s.data, 1'b1);
         opRd:
         begin
            readReg(name, s.addr, shadow[int'(s.addr)]);
            if (s.addr == regCtrl)
               chk.checkSig({name, "Port"}, "ctrl", shadow[int'(regCtrl)]);
         end
         opSts:
         begin
            {cpuHalt, cpuRun} = s.data[1:0];
            readReg(name, regStatus, s.expv);
         end
         opMdm:
         begin
            modemOut = modemOut_t'(s.data[3:0]);
            @(negedge clkT);
            chk.checkSig(name, "modemIn", s.expv);
            nextCycle();
         end
         opReq:
         begin
            activeReq = activeReq | s.reqPat;
            driveReqs();
         end
         opGnt, opSrv:
         begin
            while (grant == srcNone)
               nextCycle();
            if (s.op == opGnt)
               repeat (2) nextCycle();   // Let higher requests try to take over
            @(negedge clkT);
            chk.checkSig(name, "grant", s.expv);
            chk.checkSig(name, "memReq", reqDrive(idx));
            nextCycle();
            if (s.op == opSrv)
            begin
               memAck = 1'b1;
               @(negedge clkT);
               chk.checkSig(name, "ackOut", 32'd1 << idx);
               nextCycle();
               memAck         = 1'b0;
               activeReq[idx] = 1'b0;   // Requester drops after its ack
               driveReqs();
            end
         end
         default:
         begin
            repeat (4) nextCycle();
            @(negedge clkT);
            chk.checkSig(name, "grant", s.expv);
            nextCycle();
         end
      endcase
   endtask

   task automatic addStep(input op_e op, input cslAddr_e a, input logic [31:0] d,
                          input logic [5:0] pat, input logic [31:0] e, input string name);
      steps.push_back('{op, a, d, pat, e});
      names.push_back(name);
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   task automatic buildTable();
      addStep(opWrLock, regCtrl,  32'hF,  6'h00,     32'h0,   "ctrlWriteInReset");
      addStep(opRd,     regCtrl,  32'h0,  6'h00,     32'h0,   "ctrlUnchanged");
      addStep(opRd,     regUbaEn, 32'h0,  6'h00,     32'h0,   "ubaEnAfterReset");
      addStep(opReq,    regCtrl,  32'h0,  6'b001000, 32'h0,   "uba2Request");
      addStep(opIdle,   regCtrl,  32'h0,  6'h00,     srcNone, "uba2Masked");
      addStep(opWrFix,  regUbaEn, 32'hF,  6'h00,     32'h0,   "enableAllBridges");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba2, "uba2Enabled");
      addStep(opReq,    regCtrl,  32'h0,  6'b111111, 32'h0,   "allRequest");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcCpu,  "prioCpu");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcCsl,  "prioCsl");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba1, "prioUba1");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba2, "prioUba2");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba3, "prioUba3");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba4, "prioUba4");
      addStep(opReq,    regCtrl,  32'h0,  6'b010000, 32'h0,   "uba3Request");
      addStep(opGnt,    regCtrl,  32'h0,  6'h00,     srcUba3, "uba3Granted");
      addStep(opReq,    regCtrl,  32'h0,  6'b000001, 32'h0,   "cpuLateRequest");
      addStep(opGnt,    regCtrl,  32'h0,  6'h00,     srcUba3, "uba3KeepsGrant");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcUba3, "uba3Served");
      addStep(opSrv,    regCtrl,  32'h0,  6'h00,     srcCpu,  "cpuAfterUba3");
      addStep(opWr,     regCtrl,  32'h0,  6'h00,     32'h0,   "ctrlRandom");
      addStep(opRd,     regCtrl,  32'h0,  6'h00,     32'h0,   "ctrlReadback");
      addStep(opWr,     regModem, 32'h0,  6'h00,     32'h0,   "modemRandom");
      addStep(opRd,     regModem, 32'h0,  6'h00,     32'h0,   "modemReadback");
      addStep(opWr,     regUbaEn, 32'h0,  6'h00,     32'h0,   "ubaEnRandom");
      addStep(opRd,     regUbaEn, 32'h0,  6'h00,     32'h0,   "ubaEnReadback");
      addStep(opSts,    regCtrl,  32'h2,  6'h00,     32'h2,   "statusHalt");
      addStep(opSts,    regCtrl,  32'h1,  6'h00,     32'h1,   "statusRun");
      addStep(opWrFix,  regModem, 32'h10, 6'h00,     32'h0,   "h325On");
      addStep(opMdm,    regCtrl,  32'hA,  6'h00,     32'h54,  "loopRtsTxd");
      addStep(opMdm,    regCtrl,  32'h5,  6'h00,     32'h2B,  "loopDtrClk");
      addStep(opWrFix,  regModem, 32'hA,  6'h00,     32'h0,   "overrideRiDsr");
      addStep(opMdm,    regCtrl,  32'hF,  6'h00,     32'h2F,  "overrideA");
      addStep(opWrFix,  regModem, 32'h5,  6'h00,     32'h0,   "overrideCtsDcd");
      addStep(opMdm,    regCtrl,  32'h0,  6'h00,     32'h50,  "overrideB");
      addStep(opRd,     regModem, 32'h0,  6'h00,     32'h0,   "modemFinal");
   endtask

   initial
   begin
      seed      = 32'hdf19;
      memRST    = 1'b1;
      cslWr     = 1'b0;
      cslRd     = 1'b0;
      cslAddr   = regCtrl;
      cslWrData = '0;
      cpuHalt   = 1'b0;
      cpuRun    = 1'b0;
      modemOut  = '0;
      memAck    = 1'b0;
      activeReq = '0;
      driveReqs();
      shadow = '{ctrlReset, modemReset, ubaEnReset, 32'h0};
      buildTable();
      tmoLimit = steps.size() * cyclesPerStep + tmoMargin;
      repeat (2) @(posedge clkT);
      #1;
      memRST = 1'b0;
      foreach (steps[i])
         applyStep(steps[i], names[i]);
      $display("Checks finished with %0d errors", errCount);
      if (errCount == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: verif/ks10Check.sv
// Testbench checker for the KS10 glue logic that watches the DUT ports and counts mismatches
`timescale 1ns/1ps

module ks10Check
   import ks10BusPkg::*;
   import cslPkg::*;
(
   input  logic              clkT,
   input  logic              memRST,
   input  clkPhase_e         phase,
   input  logic              cpuClk,
   input  logic              cslRst,
   input  logic [31:0]       cslRdData,
   input  logic [3:0]        ctrl,
   input  modemIn_t          modemIn,
   input  logic              memAck,
   input  busReq_t           memReq,
   input  busSrc_e           grant,
   input  logic [numReq-1:0] ackOut,
   output int                errCount
);

   clkPhase_e expPhase = t1;
   int        relEdges = 0;      // Edges since memRST fell
   logic      relDone  = 1'b0;

   initial
      errCount = 0;

   task automatic report(input string name, input logic [63:0] expv, input logic [63:0] act);
      if (expv !== act)
      begin
         errCount++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, expv, act);
      end
   endtask

   // Called by the stimulus side with the name of the watched output
   task automatic checkSig(input string name, input string sig, input logic [63:0] expv);
      case (sig)
         "rdData":  report(name, expv, cslRdData);
         "ctrl":    report(name, expv, ctrl);
         "modemIn": report(name, expv, modemIn);
         "grant":   report(name, expv, grant);
         "memReq":  report(name, expv, memReq);
         "ackOut":  report(name, expv, ackOut);
         default:
         begin
            errCount++;
            $display("Check %s asked for an output that is not watched: %s", name, sig);
         end
      endcase
   endtask

   always @(posedge clkT)
      relEdges <= memRST ? 0 : relEdges + 1;

   //////////////////////////////
   // Checks on every cycle
   //////////////////////////////

   always @(negedge clkT)
   begin
      if (memRST)
         expPhase = t1;
      else
      begin
         report("phaseSeq", expPhase, phase);
         report("cpuClk", expPhase[3], cpuClk);   // T1 line
         if (!cslRst && !relDone)
         begin
            relDone = 1'b1;
            report("cslRstRelease", 4, relEdges);
         end
         if (grant == srcNone)
         begin
            report("idleAck", 0, ackOut);
            report("idleMemReq", 0, memReq.req);
         end
         else
            report("ackWinner", {5'd0, memAck} << (grant - 1), ackOut);
         case (phase)
            t1: expPhase = t2;
            t2: expPhase = t3;
            t3: expPhase = t4;
            default: expPhase = t1;
         endcase
      end
   end

endmodule

// File: src/ks10Core.sv
// KS10 system glue top level joining the clock sequencer, console registers and bus arbiter
`timescale 1ns/1ps

module ks10Core
   import ks10BusPkg::*;
   import cslPkg::*;
(
   input  logic              clkT,
   input  logic              memRST,
   output logic              cpuClk,
   output logic              cslRst,
   output clkPhase_e         phase,
   // Console strobes
   input  logic              cslWr,
   input  logic              cslRd,
   input  cslAddr_e          cslAddr,
   input  logic [31:0]       cslWrData,
   output logic [31:0]       cslRdData,
   // CPU status and console control
   input  logic              cpuHalt,
   input  logic              cpuRun,
   output logic [3:0]        ctrl,
   // DUP11 modem
   input  modemOut_t         modemOut,
   output modemIn_t          modemIn,
   // Backplane
   input  busReq_t           cpuReq,
   input  busReq_t           cslReq,
   input  busReq_t           ubaReq [numBridge],
   input  logic              memAck,
   output busReq_t           memReq,
   output busSrc_e           grant,
   output logic [numReq-1:0] ackOut
);

   logic [numBridge-1:0] ubaEn;   // Console to arbiter

   assign cpuClk = phase[3];      // T1 line

   phaseGen uPhaseGen (
      .clkT      (clkT),
      .memRST    (memRST),
      .phase     (phase),
      .cslRst    (cslRst)
   );

   cslRegs uCslRegs (
      .clkT      (clkT),
      .cslRst    (cslRst),
      .cslWr     (cslWr),
      .cslRd     (cslRd),
      .cslAddr   (cslAddr),
      .cslWrData (cslWrData),
      .cslRdData (cslRdData),
      .cpuHalt   (cpuHalt),
      .cpuRun    (cpuRun),
      .ctrl      (ctrl),
      .ubaEn     (ubaEn),
      .modemOut  (modemOut),
      .modemIn   (modemIn)
   );

   busArb uBusArb (
      .clkT      (clkT),
      .memRST    (memRST),
      .cpuReq    (cpuReq),
      .cslReq    (cslReq),
      .ubaReq    (ubaReq),
      .ubaEn     (ubaEn),
      .memAck    (memAck),
      .memReq    (memReq),
      .grant     (grant),
      .ackOut    (ackOut)
   );

endmodule

// File: src/busArb.sv
// Fixed-priority KS10 backplane arbiter that places one requester on the memory bus
`timescale 1ns/1ps

module busArb
   import ks10BusPkg::*;
(
   input  logic                 clkT,
   input  logic                 memRST,
   input  busReq_t              cpuReq,
   input  busReq_t              cslReq,
   input  busReq_t              ubaReq [numBridge],
   input  logic [numBridge-1:0] ubaEn,
   input  logic                 memAck,
   output busReq_t              memReq,
   output busSrc_e              grant,
   output logic [numReq-1:0]    ackOut
);

   busReq_t           reqAll [numReq];   // Index 0 cpu, 1 csl, 2..5 uba1..uba4
   logic [numReq-1:0] reqVec;            // Active and enabled requests
   logic [2:0]        grantIdx;
   busSrc_e           winner;

   //////////////////////////////
   // Request gathering
   //////////////////////////////

   always_comb
   begin
      reqAll[0] = cpuReq;
      reqAll[1] = cslReq;
      for (int i = 0; i < numBridge; i++)
         reqAll[i + 2] = ubaReq[i];
      for (int i = 0; i < numReq; i++)
         reqVec[i] = reqAll[i].req;
      reqVec[numReq-1:2] = reqVec[numReq-1:2] & ubaEn;   // Masked bridges never win
   end

   // Lowest index wins
   always_comb
   begin
      winner = srcNone;
      for (int i = numReq - 1; i >= 0; i--)
      begin
         if (reqVec[i])
            winner = busSrc_e'(i + 1);
      end
   end

   //////////////////////////////
   // Grant register
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
         grant <= srcNone;
      else if (grant == srcNone)
         grant <= winner;               // May stay idle
      else if (memAck)
         grant <= srcNone;              // Rearbitrate on the next edge
   end

   assign grantIdx = grant - 3'd1;

   //////////////////////////////
   // Memory side and acknowledge
   //////////////////////////////

   always_comb
   begin
      memReq = '0;
      ackOut = '0;
      if (grant != srcNone)
      begin
         memReq           = reqAll[grantIdx];
         ackOut[grantIdx] = memAck;     // Only the winner sees the ack
      end
   end

endmodule

// File: src/cslRegs.sv
// Console control, modem and bridge-enable registers with readback and the H325 loopback switch
`timescale 1ns/1ps

module cslRegs
   import cslPkg::*;
(
   input  logic        clkT,
   input  logic        cslRst,
   input  logic        cslWr,
   input  logic        cslRd,
   input  cslAddr_e    cslAddr,
   input  logic [31:0] cslWrData,
   output logic [31:0] cslRdData,
   input  logic        cpuHalt,
   input  logic        cpuRun,
   output logic [3:0]  ctrl,        // Bit 3 run, 2 halt, 1 cont, 0 exec
   output logic [3:0]  ubaEn,       // Bit 0 is bridge 1
   input  modemOut_t   modemOut,
   output modemIn_t    modemIn
);

   modemCtl_t   modemReg;
   logic [31:0] rdMux;

   //////////////////////////////
   // Register writes
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (cslRst)
      begin
         ctrl     <= ctrlReset;
         modemReg <= modemReset;
         ubaEn    <= ubaEnReset;
      end
      else if (cslWr)
      begin
         case (cslAddr)
            regCtrl:  ctrl     <= cslWrData[3:0];
            regModem: modemReg <= modemCtl_t'(cslWrData[4:0]);
            regUbaEn: ubaEn    <= cslWrData[3:0];
            default:  ;                        // Status is read only
         endcase
      end
   end

   //////////////////////////////
   // Readback
   //////////////////////////////

   // Only implemented bits are returned, the rest read as zero
   always_comb
   begin
      rdMux = '0;
      case (cslAddr)
         regCtrl:   rdMux[3:0] = ctrl;
         regModem:  rdMux[4:0] = modemReg;
         regUbaEn:  rdMux[3:0] = ubaEn;
         regStatus: rdMux[1:0] = {cpuHalt, cpuRun};
         default:   rdMux      = '0;
      endcase
   end

   // One cycle of latency, held until the next read
   always_ff @(posedge clkT)
   begin
      if (cslRst)
         cslRdData <= '0;
      else if (cslRd)
         cslRdData <= rdMux;
   end

   //////////////////////////////
   // H325 loopback connector
   //////////////////////////////

   always_comb
   begin
      if (modemReg.h325)
      begin
         modemIn.cts = modemOut.rts;
         modemIn.dcd = modemOut.rts;
         modemIn.dsr = modemOut.dtr;
         modemIn.ri  = modemOut.dtr;
      end
      else
      begin
         // Console drives the modem status directly
         modemIn.cts = modemReg.cts;
         modemIn.dcd = modemReg.dcd;
         modemIn.dsr = modemReg.dsr;
         modemIn.ri  = modemReg.ri;
      end
      modemIn.rxd = modemOut.txd;       // Data always looped
      modemIn.rxc = modemOut.testClk;
      modemIn.txc = modemOut.testClk;
   end

endmodule

// File: src/phaseGen.sv
// Four-phase KS10 clock sequencer that holds the console in reset for the first full turn
`timescale 1ns/1ps

module phaseGen
   import ks10BusPkg::*;
(
   input  logic      clkT,
   input  logic      memRST,
   output clkPhase_e phase,
   output logic      cslRst
);

   logic turnDone;   // Set once t4 has been left the first time

   //////////////////////////////
   // Phase rotation
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         phase    <= t1;
         turnDone <= 1'b0;
      end
      else
      begin
         case (phase)
            t1: phase <= t2;
            t2: phase <= t3;
            t3: phase <= t4;
            t4:
            begin
               phase    <= t1;
               turnDone <= 1'b1;   // First full turn complete
            end
            default: phase <= t1;  // Recover from an illegal pattern
         endcase
      end
   end

   // Console leaves reset on the edge that ends the first t4
   assign cslRst = ~turnDone;

endmodule

// File: src/cslPkg.sv
// Console register map, DUP11 modem signal groups and console register reset values
package cslPkg;

   //////////////////////////////
   // Register map
   //////////////////////////////

   typedef enum logic [1:0] {
      regCtrl   = 2'd0,   // Run, halt, cont, exec
      regModem  = 2'd1,   // H325 select and modem overrides
      regUbaEn  = 2'd2,   // Bridge enable mask
      regStatus = 2'd3    // CPU halt and run, read only
   } cslAddr_e;

   //////////////////////////////
   // DUP11 modem signals
   //////////////////////////////

   // Driven by the DUP11
   typedef struct packed {
      logic rts;
      logic dtr;
      logic txd;
      logic testClk;
   } modemOut_t;

   // Seen by the DUP11
   typedef struct packed {
      logic cts;
      logic dsr;
      logic dcd;
      logic ri;
      logic rxd;
      logic rxc;
      logic txc;
   } modemIn_t;

   // Modem register layout, h325 in bit 4 down to dcd in bit 0
   typedef struct packed {
      logic h325;
      logic ri;
      logic cts;
      logic dsr;
      logic dcd;
   } modemCtl_t;

   //////////////////////////////
   // Reset values
   //////////////////////////////

   localparam logic [3:0] ctrlReset  = 4'b0000;
   localparam modemCtl_t  modemReset = '0;
   localparam logic [3:0] ubaEnReset = 4'b1101;   // Bridge 2 not fitted

endpackage

// File: src/ks10BusPkg.sv
// Backplane bus definitions shared by the clock sequencer, arbiter and KS10 top level
package ks10BusPkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////

   localparam int busAddrW  = 18;             // Backplane address
   localparam int busDataW  = 36;             // One KS10 word
   localparam int numBridge = 4;              // Unibus bridge slots
   localparam int numReq    = numBridge + 2;  // CPU, console and the bridges

   //////////////////////////////
   // Clock phases
   //////////////////////////////

   // Four overlapping phases, one bit per clock line T1..T4
   typedef enum logic [3:0] {
      t1 = 4'b1001,
      t2 = 4'b1100,
      t3 = 4'b0110,
      t4 = 4'b0011
   } clkPhase_e;

   //////////////////////////////
   // Requesters
   //////////////////////////////

   // Grant encoding, srcNone when the bus is idle
   typedef enum logic [2:0] {
      srcNone = 3'd0,
      srcCpu  = 3'd1,
      srcCsl  = 3'd2,
      srcUba1 = 3'd3,
      srcUba2 = 3'd4,
      srcUba3 = 3'd5,
      srcUba4 = 3'd6
   } busSrc_e;

   // What one requester drives onto the backplane
   typedef struct packed {
      logic                req;     // Level request, held until ack
      logic                write;   // Write cycle when set
      logic [busAddrW-1:0] addr;
      logic [busDataW-1:0] data;
   } busReq_t;

endpackage
